//--- verif/axi_mem_testdata.txt
// op id addr len burst resp strb, then len+1 data words, all hex
// op 1 write 2 read 0 end, burst 0 FIXED 1 INCR 2 WRAP, resp 0 OKAY 2 SLVERR 3 DECERR
// Full words at 0x000 and an INCR write and read back at 0x100
1 e 0000 0 1 0 f 5a5a5a5a
1 3 0100 3 1 0 f 11111111 22222222 33333333 44444444
2 5 0100 3 1 0 0 11111111 22222222 33333333 44444444
// Full words at 0x200 to 0x208, then strobed updates merged into them
1 1 0200 0 1 0 f a5a5a5a5
1 6 0204 1 1 0 f 01020304 05060708
1 2 0200 0 1 0 5 12345678
1 0 0204 1 1 0 c aabbccdd 99887766
2 4 0200 2 1 0 0 a534a578 aabb0304 99880708
// FIXED burst keeps only the last beat
1 7 0300 2 0 0 f 0badf00d 12344321 deadbeef
2 8 0300 2 0 0 0 deadbeef deadbeef deadbeef
// WRAP and out of range bursts, data must not reach the array
1 9 0100 3 2 2 f ffffffff ffffffff ffffffff ffffffff
2 a 0100 3 2 2 0 00000000 00000000 00000000 00000000
1 b 1000 1 1 3 f 12121212 34343434
2 c 1ff0 2 1 3 0 00000000 00000000 00000000
2 d 0100 3 1 0 0 11111111 22222222 33333333 44444444
2 e 0000 0 1 0 0 5a5a5a5a
// Longest burst, 16 beats
1 f 0400 f 1 0 f
c0de0000 c0de1111 c0de2222 c0de3333 c0de4444 c0de5555 c0de6666 c0de7777
c0de8888 c0de9999 c0deaaaa c0debbbb c0decccc c0dedddd c0deeeee c0deffff
2 1 0400 f 1 0 0
c0de0000 c0de1111 c0de2222 c0de3333 c0de4444 c0de5555 c0de6666 c0de7777
c0de8888 c0de9999 c0deaaaa c0debbbb c0decccc c0dedddd c0deeeee c0deffff
// End of records
0

//--- list.f
logic/axi_pkg.sv
logic/mem_pkg.sv
logic/burst_decode.sv
logic/mem_array.sv
logic/write_response.sv
logic/read_response.sv
logic/axi_mem_top.sv
verif/axi_mem_properties.sv
verif/axi_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the AXI memory testbench with Verilator and runs it from the project root.
# Exits with status 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module axi_mem_tb --Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vaxi_mem_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verif/axi_mem_tb.sv
// Reads burst records from verif/axi_mem_testdata.txt, so it must run from the project root.
// The record list runs twice, the second round with random b_ready and r_ready stalls.
// Reads only cover bytes written earlier in the same round.

module axi_mem_tb;

  localparam int TD_DEPTH      = 512;
  localparam int RESET_CYCLES  = 16;
  localparam int RECORD_CYCLES = 40;
  localparam int ROUNDS        = 2;

  logic                       clk_i;
  logic                       reset_i;
  logic                       aw_valid_i;
  logic                       aw_ready_o;
  logic [mem_pkg::ADDR_W-1:0] aw_addr_i;
  logic [axi_pkg::LEN_W-1:0]  aw_len_i;
  axi_pkg::burst_e            aw_burst_i;
  logic [mem_pkg::ID_W-1:0]   aw_id_i;
  logic                       w_valid_i;
  logic                       w_ready_o;
  logic [mem_pkg::DATA_W-1:0] w_data_i;
  logic [mem_pkg::STRB_W-1:0] w_strb_i;
  logic                       w_last_i;
  logic                       b_valid_o;
  logic                       b_ready_i;
  logic [mem_pkg::ID_W-1:0]   b_id_o;
  axi_pkg::resp_e             b_resp_o;
  logic                       ar_valid_i;
  logic                       ar_ready_o;
  logic [mem_pkg::ADDR_W-1:0] ar_addr_i;
  logic [axi_pkg::LEN_W-1:0]  ar_len_i;
  axi_pkg::burst_e            ar_burst_i;
  logic [mem_pkg::ID_W-1:0]   ar_id_i;
  logic                       r_valid_o;
  logic                       r_ready_i;
  logic [mem_pkg::DATA_W-1:0] r_data_o;
  logic [mem_pkg::ID_W-1:0]   r_id_o;
  axi_pkg::resp_e             r_resp_o;
  logic                       r_last_o;

  logic [31:0] tdata [TD_DEPTH];
  logic [31:0] rng_state;
  logic        stalls_on;
  int          n_records;

  axi_mem_top axi_mem_top_i (.*);

  always #4 clk_i = ~clk_i;

  // Xorshift32 step
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Drops ready about one cycle in four once stalls are on
  function automatic logic draw_ready();
    if (!stalls_on) begin
      return 1'b1;
    end
    return (next_random() & 32'h3) != 32'h0;
  endfunction

  // Seven header words plus one data word per beat
  function automatic int record_size(input int p);
    return 8 + int'(tdata[p + 3][axi_pkg::LEN_W-1:0]);
  endfunction

  function automatic int count_records();
    int p;
    int n;
    p = 0;
    n = 0;
    while (p < TD_DEPTH && tdata[p] != 32'h0) begin
      n++;
      p += record_size(p);
    end
    return n;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_b(input logic [mem_pkg::ID_W-1:0] id, input axi_pkg::resp_e resp);
    if (b_id_o !== id) begin
      stop_on_error($sformatf("B id %0h, expected %0h", b_id_o, id));
    end
    if (b_resp_o !== resp) begin
      stop_on_error($sformatf("B resp %s, expected %s", b_resp_o.name(), resp.name()));
    end
  endtask

  task automatic check_r(input logic [mem_pkg::ID_W-1:0] id,
                         input logic [mem_pkg::DATA_W-1:0] data,
                         input axi_pkg::resp_e resp, input logic last);
    if (r_data_o !== data) begin
      stop_on_error($sformatf("R data %08h, expected %08h", r_data_o, data));
    end
    if (r_resp_o !== resp) begin
      stop_on_error($sformatf("R resp %s, expected %s", r_resp_o.name(), resp.name()));
    end
    if (r_id_o !== id) begin
      stop_on_error($sformatf("R id %0h, expected %0h", r_id_o, id));
    end
    if (r_last_o !== last) begin
      stop_on_error($sformatf("R last %b, expected %b", r_last_o, last));
    end
  endtask

  task automatic write_burst(input int p);
    logic [mem_pkg::ID_W-1:0]  id;
    logic [axi_pkg::LEN_W-1:0] len;
    axi_pkg::resp_e            resp;
    int                        beat;
    logic                      got_b;
    id         = tdata[p + 1][mem_pkg::ID_W-1:0];
    len        = tdata[p + 3][axi_pkg::LEN_W-1:0];
    resp       = axi_pkg::resp_e'(tdata[p + 5][1:0]);
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = tdata[p + 2][mem_pkg::ADDR_W-1:0];
    aw_len_i   = len;
    aw_burst_i = axi_pkg::burst_e'(tdata[p + 4][1:0]);
    while (!aw_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    // Same strobe on every beat of a record
    for (beat = 0; beat <= int'(len); beat++) begin
      w_valid_i = 1'b1;
      w_data_i  = tdata[p + 7 + beat];
      w_strb_i  = tdata[p + 6][mem_pkg::STRB_W-1:0];
      w_last_i  = (beat == int'(len));
      while (!w_ready_o) begin
        @(negedge clk_i);
      end
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    got_b     = 1'b0;
    while (!got_b) begin
      b_ready_i = draw_ready();
      if (b_valid_o && b_ready_i) begin
        check_b(id, resp);
        got_b = 1'b1;
      end
      @(negedge clk_i);
    end
    b_ready_i = 1'b0;
  endtask

  task automatic read_burst(input int p);
    logic [mem_pkg::ID_W-1:0]  id;
    logic [axi_pkg::LEN_W-1:0] len;
    axi_pkg::resp_e            resp;
    int                        beat;
    id         = tdata[p + 1][mem_pkg::ID_W-1:0];
    len        = tdata[p + 3][axi_pkg::LEN_W-1:0];
    resp       = axi_pkg::resp_e'(tdata[p + 5][1:0]);
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = tdata[p + 2][mem_pkg::ADDR_W-1:0];
    ar_len_i   = len;
    ar_burst_i = axi_pkg::burst_e'(tdata[p + 4][1:0]);
    while (!ar_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    beat       = 0;
    while (beat <= int'(len)) begin
      r_ready_i = draw_ready();
      if (r_valid_o && r_ready_i) begin
        check_r(id, tdata[p + 7 + beat], resp, beat == int'(len));
        beat++;
      end
      @(negedge clk_i);
    end
    r_ready_i = 1'b0;
    // Nothing may follow the beat with r_last
    if (r_valid_o) begin
      stop_on_error("R beat presented after the last beat of the burst");
    end
  endtask

  task automatic run_records();
    int p;
    p = 0;
    while (p < TD_DEPTH && tdata[p] != 32'h0) begin
      if (tdata[p] == 32'h1) begin
        write_burst(p);
      end else begin
        read_burst(p);
      end
      p += record_size(p);
    end
  endtask

  initial begin
    int i;
    int round;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_burst_i = axi_pkg::INCR;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_burst_i = axi_pkg::INCR;
    ar_id_i    = '0;
    r_ready_i  = 1'b0;
    rng_state  = 32'd88;
    stalls_on  = 1'b0;
    for (i = 0; i < TD_DEPTH; i++) begin
      tdata[i] = 32'h0;
    end
    $readmemh("verif/axi_mem_testdata.txt", tdata);
    n_records = count_records();
    if (n_records == 0) begin
      $display("The testdata file holds no burst records");
      $display("Test failed");
      $fatal(1, "no stimulus");
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    for (round = 0; round < ROUNDS; round++) begin
      stalls_on = (round == 1);
      run_records();
    end
    $display("Test completed successfully");
    $finish;
  end

  // Budget grows with the number of records run
  initial begin : watchdog
    int limit;
    wait (n_records > 0);
    limit = ROUNDS * n_records * RECORD_CYCLES + RESET_CYCLES;
    repeat (limit) @(posedge clk_i);
    $display("Timeout, the bursts did not finish within %0d cycles", limit);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verif/axi_mem_properties.sv
// Handshake checks bound into axi_mem_top.
// Master side rules check the stimulus, slave side rules check the DUT.
// The write beat count is taken from the decoder last flag in the top level.

module axi_mem_properties (
  input logic                       clk_i,
  input logic                       reset_i,
  input logic                       aw_valid_i,
  input logic                       aw_ready_i,
  input logic [mem_pkg::ADDR_W-1:0] aw_addr_i,
  input logic [axi_pkg::LEN_W-1:0]  aw_len_i,
  input logic                       w_valid_i,
  input logic                       w_ready_i,
  input logic [mem_pkg::DATA_W-1:0] w_data_i,
  input logic                       w_last_i,
  input logic                       wr_last_i,
  input logic                       b_valid_i,
  input logic                       b_ready_i,
  input axi_pkg::resp_e             b_resp_i,
  input logic                       ar_valid_i,
  input logic                       ar_ready_i,
  input logic [mem_pkg::ADDR_W-1:0] ar_addr_i,
  input logic [axi_pkg::LEN_W-1:0]  ar_len_i,
  input logic                       r_valid_i,
  input logic                       r_ready_i,
  input logic [mem_pkg::DATA_W-1:0] r_data_i,
  input logic                       r_last_i
);

  // Valid and payload hold until the transfer
  assert property (@(posedge clk_i) disable iff (reset_i)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i) && $stable(aw_len_i))
    else $error("AW dropped or changed before aw_ready");

  assert property (@(posedge clk_i) disable iff (reset_i)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_last_i))
    else $error("W dropped or changed before w_ready");

  assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i) && $stable(ar_len_i))
    else $error("AR dropped or changed before ar_ready");

  assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
    else $error("B dropped or changed before b_ready");

  assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_last_i))
    else $error("R dropped or changed before r_ready");

  // w_last only on the beat the AW length calls last
  assert property (@(posedge clk_i) disable iff (reset_i)
    w_valid_i && w_ready_i |-> (w_last_i == wr_last_i))
    else $error("w_last does not match the burst beat count");

  // After reset b_valid stays low until a last W beat is taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(b_valid_i) |-> $past(w_valid_i && w_ready_i && w_last_i))
    else $error("b_valid raised without a last W beat");

endmodule

bind axi_mem_top axi_mem_properties u_axi_mem_props (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .aw_valid_i (aw_valid_i),
  .aw_ready_i (aw_ready_o),
  .aw_addr_i  (aw_addr_i),
  .aw_len_i   (aw_len_i),
  .w_valid_i  (w_valid_i),
  .w_ready_i  (w_ready_o),
  .w_data_i   (w_data_i),
  .w_last_i   (w_last_i),
  .wr_last_i  (wr_last),
  .b_valid_i  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .b_resp_i   (b_resp_o),
  .ar_valid_i (ar_valid_i),
  .ar_ready_i (ar_ready_o),
  .ar_addr_i  (ar_addr_i),
  .ar_len_i   (ar_len_i),
  .r_valid_i  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .r_data_i   (r_data_o),
  .r_last_i   (r_last_o)
);

//--- logic/axi_mem_top.sv
// AXI4 memory slave, 4 KiB, 32-bit data, one burst per direction at a time.
// Supports FIXED and INCR bursts of up to 16 full-width beats.
// WRAP bursts get SLVERR, start addresses past the array get DECERR.

module axi_mem_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // Write address
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  logic [mem_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [axi_pkg::LEN_W-1:0]  aw_len_i,
  input  axi_pkg::burst_e            aw_burst_i,
  input  logic [mem_pkg::ID_W-1:0]   aw_id_i,
  // Write data
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  logic [mem_pkg::DATA_W-1:0] w_data_i,
  input  logic [mem_pkg::STRB_W-1:0] w_strb_i,
  input  logic                       w_last_i,
  // Write response
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output logic [mem_pkg::ID_W-1:0]   b_id_o,
  output axi_pkg::resp_e             b_resp_o,
  // Read address
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  logic [mem_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic [axi_pkg::LEN_W-1:0]  ar_len_i,
  input  axi_pkg::burst_e            ar_burst_i,
  input  logic [mem_pkg::ID_W-1:0]   ar_id_i,
  // Read data
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output logic [mem_pkg::DATA_W-1:0] r_data_o,
  output logic [mem_pkg::ID_W-1:0]   r_id_o,
  output axi_pkg::resp_e             r_resp_o,
  output logic                       r_last_o
);

  logic [mem_pkg::WORD_AW-1:0] wr_word;
  logic                        wr_last;
  axi_pkg::resp_e              wr_err;
  logic [mem_pkg::ID_W-1:0]    wr_id;
  logic                        wr_busy;
  logic                        wr_advance;
  logic                        wr_done;
  logic                        wr_en;

  logic                        rd_beat;
  logic [mem_pkg::WORD_AW-1:0] rd_word;
  logic                        rd_last;
  axi_pkg::resp_e              rd_err;
  logic [mem_pkg::ID_W-1:0]    rd_id;
  logic                        rd_advance;
  logic                        rd_done;
  logic                        rd_en;
  logic [mem_pkg::DATA_W-1:0]  rd_data;

  // Read decoder is released by the advance on its last beat
  assign rd_done = rd_advance && rd_last;

  burst_decode u_wr_dec (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (aw_valid_i),
    .req_ready_o (aw_ready_o),
    .req_addr_i  (aw_addr_i),
    .req_len_i   (aw_len_i),
    .req_burst_i (aw_burst_i),
    .req_id_i    (aw_id_i),
    .advance_i   (wr_advance),
    .done_i      (wr_done),
    .beat_o      (),
    .word_o      (wr_word),
    .last_o      (wr_last),
    .err_o       (wr_err),
    .id_o        (wr_id),
    .busy_o      (wr_busy)
  );

  burst_decode u_rd_dec (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (ar_valid_i),
    .req_ready_o (ar_ready_o),
    .req_addr_i  (ar_addr_i),
    .req_len_i   (ar_len_i),
    .req_burst_i (ar_burst_i),
    .req_id_i    (ar_id_i),
    .advance_i   (rd_advance),
    .done_i      (rd_done),
    .beat_o      (rd_beat),
    .word_o      (rd_word),
    .last_o      (rd_last),
    .err_o       (rd_err),
    .id_o        (rd_id),
    .busy_o      ()
  );

  mem_array u_mem (
    .clk_i     (clk_i),
    .wr_en_i   (wr_en),
    .wr_word_i (wr_word),
    .wr_strb_i (w_strb_i),
    .wr_data_i (w_data_i),
    .rd_en_i   (rd_en),
    .rd_word_i (rd_word),
    .rd_data_o (rd_data)
  );

  write_response u_wr_resp (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .busy_i    (wr_busy),
    .last_i    (wr_last),
    .err_i     (wr_err),
    .id_i      (wr_id),
    .w_valid_i (w_valid_i),
    .w_ready_o (w_ready_o),
    .w_strb_i  (w_strb_i),
    .wr_en_o   (wr_en),
    .advance_o (wr_advance),
    .done_o    (wr_done),
    .b_valid_o (b_valid_o),
    .b_ready_i (b_ready_i),
    .b_id_o    (b_id_o),
    .b_resp_o  (b_resp_o)
  );

  read_response u_rd_resp (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .beat_i    (rd_beat),
    .last_i    (rd_last),
    .err_i     (rd_err),
    .id_i      (rd_id),
    .advance_o (rd_advance),
    .rd_en_o   (rd_en),
    .rd_data_i (rd_data),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i),
    .r_data_o  (r_data_o),
    .r_id_o    (r_id_o),
    .r_resp_o  (r_resp_o),
    .r_last_o  (r_last_o)
  );

endmodule

//--- logic/read_response.sv
// Issues array reads for the active read burst and drives the R channel.
// At most two beats are outstanding across the array read, the holding
// register and the output register. The decoder is only stepped past the
// last beat at the last R handshake, so id and resp stay valid till then.

module read_response (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       beat_i,
  input  logic                       last_i,
  input  axi_pkg::resp_e             err_i,
  input  logic [mem_pkg::ID_W-1:0]   id_i,
  output logic                       advance_o,
  output logic                       rd_en_o,
  input  logic [mem_pkg::DATA_W-1:0] rd_data_i,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output logic [mem_pkg::DATA_W-1:0] r_data_o,
  output logic [mem_pkg::ID_W-1:0]   r_id_o,
  output axi_pkg::resp_e             r_resp_o,
  output logic                       r_last_o
);

  logic                       fly_valid_q;
  logic                       fly_last_q;
  logic                       hold_valid_q;
  logic                       hold_last_q;
  logic [mem_pkg::DATA_W-1:0] hold_data_q;
  logic                       out_valid_q;
  logic                       out_last_q;
  logic [mem_pkg::DATA_W-1:0] out_data_q;
  logic                       last_issued_q;
  logic [mem_pkg::DATA_W-1:0] fly_data;
  logic [1:0]                 occ;
  logic                       r_hs;
  logic                       issue;
  logic                       out_load;

  assign r_hs = out_valid_q && r_ready_i;

  // Beats that will still be held after this cycle
  assign occ   = 2'(fly_valid_q) + 2'(hold_valid_q) + 2'(out_valid_q) - 2'(r_hs);
  assign issue = beat_i && !last_issued_q && (occ < 2'd2);

  assign rd_en_o   = issue && (err_i == axi_pkg::OKAY);
  assign advance_o = (issue && !last_i) || (r_hs && out_last_q);

  // Error bursts return zero data
  assign fly_data = (err_i == axi_pkg::OKAY) ? rd_data_i : '0;
  assign out_load = r_hs || !out_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fly_valid_q   <= 1'b0;
      hold_valid_q  <= 1'b0;
      out_valid_q   <= 1'b0;
      last_issued_q <= 1'b0;
    end else begin
      fly_valid_q <= issue;
      if (out_load) begin
        out_valid_q  <= hold_valid_q || fly_valid_q;
        hold_valid_q <= 1'b0;
      end else if (fly_valid_q) begin
        hold_valid_q <= 1'b1;
      end
      if (issue && last_i) begin
        last_issued_q <= 1'b1;
      end else if (r_hs && out_last_q) begin
        last_issued_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      fly_last_q <= last_i;
    end
    if (out_load) begin
      if (hold_valid_q) begin
        out_data_q <= hold_data_q;
        out_last_q <= hold_last_q;
      end else begin
        out_data_q <= fly_data;
        out_last_q <= fly_last_q && fly_valid_q;
      end
    end else if (fly_valid_q) begin
      // Output stalled, catch the word coming out of the array
      hold_data_q <= fly_data;
      hold_last_q <= fly_last_q;
    end
  end

  assign r_valid_o = out_valid_q;
  assign r_data_o  = out_data_q;
  assign r_last_o  = out_last_q;
  assign r_id_o    = id_i;
  assign r_resp_o  = err_i;

endmodule

//--- logic/write_response.sv
// Accepts W beats for the active write burst and returns the B response.
// The beat count comes from the decoder, w_last is not looked at here.
// Error bursts still take all their beats but never write the array.

module write_response (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       busy_i,
  input  logic                       last_i,
  input  axi_pkg::resp_e             err_i,
  input  logic [mem_pkg::ID_W-1:0]   id_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  logic [mem_pkg::STRB_W-1:0] w_strb_i,
  output logic                       wr_en_o,
  output logic                       advance_o,
  output logic                       done_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output logic [mem_pkg::ID_W-1:0]   b_id_o,
  output axi_pkg::resp_e             b_resp_o
);

  logic                     b_valid_q;
  logic [mem_pkg::ID_W-1:0] b_id_q;
  axi_pkg::resp_e           b_resp_q;
  logic                     w_hs;

  // W is closed while a B response is pending
  assign w_ready_o = busy_i && !b_valid_q;
  assign w_hs      = w_valid_i && w_ready_o;
  assign advance_o = w_hs;
  assign wr_en_o   = w_hs && (err_i == axi_pkg::OKAY) && (|w_strb_i);
  assign done_o    = b_valid_q && b_ready_i;

  assign b_valid_o = b_valid_q;
  assign b_id_o    = b_id_q;
  assign b_resp_o  = b_resp_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
    end else if (w_hs && last_i) begin
      b_valid_q <= 1'b1;
    end else if (done_o) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_hs && last_i) begin
      b_id_q   <= id_i;
      b_resp_q <= err_i;
    end
  end

endmodule

//--- logic/mem_array.sv
// Word memory with one byte-strobed write port and one read port.
// Read data is registered and appears the cycle after rd_en_i.
// Contents are not initialized.

module mem_array (
  input  logic                        clk_i,
  input  logic                        wr_en_i,
  input  logic [mem_pkg::WORD_AW-1:0] wr_word_i,
  input  logic [mem_pkg::STRB_W-1:0]  wr_strb_i,
  input  logic [mem_pkg::DATA_W-1:0]  wr_data_i,
  input  logic                        rd_en_i,
  input  logic [mem_pkg::WORD_AW-1:0] rd_word_i,
  output logic [mem_pkg::DATA_W-1:0]  rd_data_o
);

  logic [mem_pkg::DATA_W-1:0] mem_q [mem_pkg::MEM_WORDS];

  // Byte lanes
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int b = 0; b < mem_pkg::STRB_W; b++) begin
        if (wr_strb_i[b]) begin
          mem_q[wr_word_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_word_i];
    end
  end

endmodule

//--- logic/burst_decode.sv
// Accepts one address request at a time and walks its beat word indexes.
// The low address bits inside a word are ignored, full-width beats only.
// An INCR burst that runs past the top word wraps around the array.
// Errors are decided from the start address, burst type and length.

module burst_decode (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [mem_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [axi_pkg::LEN_W-1:0]  req_len_i,
  input  axi_pkg::burst_e            req_burst_i,
  input  logic [mem_pkg::ID_W-1:0]   req_id_i,
  input  logic                       advance_i,
  input  logic                       done_i,
  output logic                       beat_o,
  output logic [mem_pkg::WORD_AW-1:0] word_o,
  output logic                       last_o,
  output axi_pkg::resp_e             err_o,
  output logic [mem_pkg::ID_W-1:0]   id_o,
  output logic                       busy_o
);

  // Byte offset bits below the word index
  localparam int unsigned OFFS_W = $clog2(mem_pkg::STRB_W);

  mem_pkg::dec_state_e         state_q;
  mem_pkg::dec_state_e         state_d;
  logic [mem_pkg::WORD_AW-1:0] word_q;
  logic [axi_pkg::LEN_W-1:0]   len_q;
  logic [axi_pkg::LEN_W-1:0]   cnt_q;
  axi_pkg::burst_e             burst_q;
  logic [mem_pkg::ID_W-1:0]    id_q;
  axi_pkg::resp_e              err_q;
  axi_pkg::resp_e              req_err;
  logic                        req_hs;
  logic                        step;

  assign req_ready_o = (state_q == mem_pkg::IDLE);
  assign req_hs      = req_valid_i && req_ready_o;
  assign beat_o      = (state_q == mem_pkg::BURST);
  assign busy_o      = (state_q != mem_pkg::IDLE);
  assign last_o      = (cnt_q == len_q);
  assign step        = advance_i && beat_o;

  assign word_o = word_q;
  assign err_o  = err_q;
  assign id_o   = id_q;

  // Address range first, then burst type and length
  always_comb begin
    req_err = axi_pkg::OKAY;
    if (32'(req_addr_i) >= mem_pkg::MEM_WORDS * mem_pkg::STRB_W) begin
      req_err = axi_pkg::DECERR;
    end else if (!(req_burst_i inside {axi_pkg::FIXED, axi_pkg::INCR})) begin
      req_err = axi_pkg::SLVERR;
    end else if (req_len_i > axi_pkg::LEN_W'(axi_pkg::MAX_LEN)) begin
      req_err = axi_pkg::SLVERR;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_pkg::IDLE: begin
        if (req_hs) begin
          state_d = mem_pkg::BURST;
        end
      end
      mem_pkg::BURST: begin
        // Read side releases straight from the last beat
        if (step && last_o) begin
          state_d = done_i ? mem_pkg::IDLE : mem_pkg::RESP;
        end
      end
      mem_pkg::RESP: begin
        if (done_i) begin
          state_d = mem_pkg::IDLE;
        end
      end
      default: state_d = mem_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= mem_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request fields and beat counter, reloaded on every request
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      word_q  <= req_addr_i[OFFS_W +: mem_pkg::WORD_AW];
      len_q   <= req_len_i;
      cnt_q   <= '0;
      burst_q <= req_burst_i;
      id_q    <= req_id_i;
      err_q   <= req_err;
    end else if (step) begin
      cnt_q <= cnt_q + 1'b1;
      // FIXED bursts stay on the start word
      if (burst_q == axi_pkg::INCR) begin
        word_q <= word_q + 1'b1;
      end
    end
  end

endmodule

//--- logic/mem_pkg.sv
// Memory geometry and the burst decoder states.
// All transfers are full bus width, so a beat always covers one word.

package mem_pkg;

  localparam int unsigned ADDR_W    = 16;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned STRB_W    = DATA_W / 8;
  localparam int unsigned ID_W      = 4;
  localparam int unsigned MEM_WORDS = 1024;
  localparam int unsigned WORD_AW   = 10;

  // Burst decoder FSM
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    BURST = 2'b01,
    RESP  = 2'b10
  } dec_state_e;

endpackage

//--- logic/axi_pkg.sv
// AXI4 protocol encodings shared by the memory slave.
// Only the burst types and response codes this slave uses are listed;
// burst encoding 2'b11 is reserved and is treated as an error burst.

package axi_pkg;

  // Burst length field and the longest burst the slave accepts
  localparam int unsigned LEN_W   = 8;
  localparam int unsigned MAX_LEN = 15;

  // AXI AxBURST encoding
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // AXI xRESP encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

endpackage
